// File: verif/sdram_cmd_golden.txt
# port(0 rand, 1 bulk) we addr refresh join ncmd, then four slots of: cmd addr bank (hex)
# join 1 holds the request with the next line; cmd 3 actv, 5 read, 4 wrte, 2 prch, 1 arsr
# refresh first with no page open, then hits and misses on one port at a time
0 0 0049034 1 0 3 1 0000 0 3 0012 1 5 0068 1 0 0000 0
0 1 0049100 0 0 1 4 0200 1 0 0000 0 0 0000 0 0 0000 0
1 0 00497ff 0 0 1 5 0ffe 1 0 0000 0 0 0000 0 0 0000 0
1 1 2af2005 0 0 3 2 0400 0 3 12bc 2 4 000a 2 0 0000 0
0 0 2af3010 0 0 3 2 0400 0 3 12bc 3 5 0020 3 0 0000 0
0 0 2af3020 1 0 4 2 0400 0 1 0000 0 3 12bc 3 5 0040 3
1 1 2af3fff 0 0 1 4 1ffe 3 0 0000 0 0 0000 0 0 0000 0
# bulk and rand held together, bulk served first
1 0 05540aa 0 1 3 2 0400 0 3 0155 0 5 0154 0 0 0000 0
0 1 2af3001 0 0 3 2 0400 0 3 12bc 3 4 0002 3 0 0000 0
1 0 2af3100 0 1 1 5 0200 3 0 0000 0 0 0000 0 0 0000 0
0 0 2af3200 0 0 1 5 0400 3 0 0000 0 0 0000 0 0 0000 0
# high and low row bits
0 1 3ffc000 0 0 3 2 0400 0 3 1bff 0 4 0000 0 0 0000 0
0 0 3ffcfff 0 0 1 5 1ffe 0 0 0000 0 0 0000 0 0 0000 0
1 0 3ffc800 1 0 4 2 0400 0 1 0000 0 3 1bff 0 5 1000 0
1 1 1001123 0 0 3 2 0400 0 3 0800 1 4 0246 1 0 0000 0
0 0 0ffd456 0 0 3 2 0400 0 3 03ff 1 5 08ac 1 0 0000 0
# refresh with a pair held, then a pair where only bulk hits
1 1 0ffd001 1 1 4 2 0400 0 1 0000 0 3 03ff 1 4 0002 1
0 0 0ffd002 0 0 1 5 0004 1 0 0000 0 0 0000 0 0 0000 0
1 0 0ffd010 0 1 1 5 0020 1 0 0000 0 0 0000 0 0 0000 0
0 1 0006003 0 0 3 2 0400 0 3 0001 2 4 0006 2 0 0000 0
1 0 0006abc 0 0 1 5 1578 2 0 0000 0 0 0000 0 0 0000 0
0 1 0000000 0 0 3 2 0400 0 3 0000 0 4 0000 0 0 0000 0
0 0 0000001 1 0 4 2 0400 0 1 0000 0 3 0000 0 5 0002 0
1 1 20033c3 0 0 3 2 0400 0 3 1000 3 4 0786 3 0 0000 0
# same row, other bank
1 0 2002001 0 1 3 2 0400 0 3 1000 2 5 0002 2 0 0000 0
0 0 2003002 0 0 3 2 0400 0 3 1000 3 5 0004 3 0 0000 0
1 0 2003555 1 0 4 2 0400 0 1 0000 0 3 1000 3 5 0aaa 3
0 1 20037fe 0 0 1 4 0ffc 3 0 0000 0 0 0000 0 0 0000 0

// File: files.f
logic/sdram_cmd_pkg.sv
logic/host_port_pkg.sv
logic/cmd_sequencer.sv
logic/cmd_timer.sv
logic/page_tracker.sv
logic/cmd_output_reg.sv
logic/sdram_cmd_ctrl.sv
verif/sdram_cmd_chk.sv
verif/sdram_cmd_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --timing --assert
TOP       := sdram_cmd_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
PASS_MSG  := all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/sdram_cmd_tb.sv
`timescale 1ns/1ps

module sdram_cmd_tb;
  import sdram_cmd_pkg::*;
  import host_port_pkg::*;

  localparam int T_RFC     = 13;
  localparam int T_RCD     = 4;
  localparam int T_RP      = 4;
  localparam int T_RW      = 4;
  localparam int MAX_LINES = 64;
  localparam int MAX_CMDS  = 4;                 // command slots per golden line
  localparam logic [12:0] RESET_ADDR = 13'h0400;  // a10 set

  typedef struct packed {
    logic [2:0]  cmd;
    logic [12:0] addr;
    logic [1:0]  bank;
  } cmd_rec_t;

  logic       CLK;
  logic       RST;
  logic       refresh_strobe;
  port_req_t  rand_req;
  port_req_t  bulk_req;
  sdram_cmd_t command;
  dev_addr_t  address;
  bank_t      bank;
  logic       grant_rand;
  logic       grant_bulk;

  int         line_port [MAX_LINES];  // 1 for bulk
  logic       line_we   [MAX_LINES];
  host_addr_t line_addr [MAX_LINES];
  logic       line_rfsh [MAX_LINES];
  logic       line_join [MAX_LINES];  // held together with next line
  int         line_ncmd [MAX_LINES];
  cmd_rec_t   line_exp  [MAX_LINES][MAX_CMDS];
  int         num_lines;
  cmd_rec_t   seen_q [$];
  int         errors;
  int         checks;
  int         timeout_limit;
  int         cycle_count;
  integer     seed;

  sdram_cmd_ctrl #(
    .T_RFC (T_RFC),
    .T_RCD (T_RCD),
    .T_RP  (T_RP),
    .T_RW  (T_RW)
  ) sdram_cmd_ctrl_i (
    .CLK            (CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe),
    .rand_req       (rand_req),
    .bulk_req       (bulk_req),
    .command        (command),
    .address        (address),
    .bank           (bank),
    .grant_rand     (grant_rand),
    .grant_bulk     (grant_bulk)
  );

  initial
  begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // every non-noop command in issue order
  always @(negedge CLK)
  begin
    if (RST && (command != cmd_noop))
      seen_q.push_back({command, address, bank});
  end

  task automatic compare_value(input string name, input int got, input int exp);
    checks++;
    if (got != exp)
    begin
      errors++;
      $display("Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic read_golden();
    int    fd;
    int    rc;
    int    k;
    int    fld [18];
    string text;
    num_lines = 0;
    fd = $fopen("verif/sdram_cmd_golden.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("golden file verif/sdram_cmd_golden.txt could not be opened");
      return;
    end
    while (!$feof(fd) && (num_lines < MAX_LINES))
    begin
      rc = $fgets(text, fd);
      if ((rc > 0) && (text.getc(0) != "#"))
      begin
        rc = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                     fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                     fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14],
                     fld[15], fld[16], fld[17]);
        if ((rc == 18) && (fld[5] <= MAX_CMDS))
        begin
          line_port[num_lines] = fld[0];
          line_we[num_lines]   = fld[1][0];
          line_addr[num_lines] = host_addr_t'(fld[2]);
          line_rfsh[num_lines] = fld[3][0];
          line_join[num_lines] = fld[4][0];
          line_ncmd[num_lines] = fld[5];
          for (k = 0; k < MAX_CMDS; k++)
            line_exp[num_lines][k] = {fld[6+3*k][2:0], fld[7+3*k][12:0], fld[8+3*k][1:0]};
          num_lines++;
        end
        else if (rc > 0)
        begin
          errors++;
          $display("golden line could not be parsed: %s", text);
        end
      end
    end
    $fclose(fd);
    if (num_lines == 0)
    begin
      errors++;
      $display("golden file holds no request lines");
    end
  endtask

  task automatic drive_request(input int idx);
    port_req_t r;
    r.req  = 1'b1;
    r.we   = line_we[idx];
    r.addr = line_addr[idx];
    if (line_port[idx] == 1)
      bulk_req = r;
    else
      rand_req = r;
  endtask

  // drive lines first to last together and compare commands after all grants
  task automatic serve_group(input int first, input int last);
    int       k;
    int       j;
    int       n_exp;
    logic     got_bulk;
    cmd_rec_t got;
    cmd_rec_t exp;
    @(posedge CLK);
    #1;
    if (line_rfsh[first])
      refresh_strobe = ~refresh_strobe;
    for (k = first; k <= last; k++)
      drive_request(k);
    k = first;
    while (k <= last)
    begin
      @(negedge CLK);
      if (grant_bulk || grant_rand)
      begin
        got_bulk = grant_bulk;
        compare_value("grant_bulk", int'(got_bulk), (line_port[k] == 1) ? 1 : 0);
        @(posedge CLK);
        #1;
        if (got_bulk)
          bulk_req = '0;
        else
          rand_req = '0;
        k++;
      end
    end
    n_exp = 0;
    for (k = first; k <= last; k++)
      n_exp += line_ncmd[k];
    compare_value("command count", seen_q.size(), n_exp);
    for (k = first; k <= last; k++)
    begin
      for (j = 0; j < line_ncmd[k]; j++)
      begin
        if (seen_q.size() > 0)
        begin
          got = seen_q.pop_front();
          exp = line_exp[k][j];
          compare_value("command", int'(got.cmd), int'(exp.cmd));
          compare_value("address", int'(got.addr), int'(exp.addr));
          compare_value("bank", int'(got.bank), int'(exp.bank));
        end
      end
    end
  endtask

  initial
  begin
    cycle_count = 0;
    @(posedge CLK);
    while ((timeout_limit == 0) || (cycle_count < timeout_limit))
    begin
      @(posedge CLK);
      cycle_count++;
    end
    $display("timeout after %0d cycles, a grant never arrived", cycle_count);
    $display("tests failed");
    $finish;
  end

  initial
  begin
    int first;
    int last;
    int gap;
    errors         = 0;
    checks         = 0;
    timeout_limit  = 0;
    seed           = 32'h10d87960;
    RST            = 1'b0;
    refresh_strobe = 1'b0;
    rand_req       = '0;
    bulk_req       = '0;
    read_golden();
    timeout_limit = num_lines * 4 * (T_RFC + 4) + 200;
    repeat (7) @(posedge CLK);
    @(negedge CLK);
    compare_value("command", int'(command), int'(cmd_noop));
    compare_value("address", int'(address), int'(RESET_ADDR));
    compare_value("grant_rand", int'(grant_rand), 0);
    compare_value("grant_bulk", int'(grant_bulk), 0);
    @(posedge CLK);
    #1;
    RST = 1'b1;
    first = 0;
    while (first < num_lines)
    begin
      last = first;
      while (line_join[last] && (last + 1 < num_lines))
        last++;
      serve_group(first, last);
      gap = $unsigned($random(seed)) % 5;  // idle cycles between requests
      repeat (gap) @(posedge CLK);
      first = last + 1;
    end
    repeat (T_RFC + 4) @(posedge CLK);
    compare_value("command count after last grant", seen_q.size(), 0);
    errors += sdram_cmd_ctrl_i.sdram_cmd_chk_i.fail_count;
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// File: verif/sdram_cmd_chk.sv
`timescale 1ns/1ps

module sdram_cmd_chk #(
  parameter int T_RFC = 13,
  parameter int T_RCD = 4,
  parameter int T_RP  = 4,
  parameter int T_RW  = 4
) (
  input logic                      CLK,
  input logic                      RST,
  input sdram_cmd_pkg::sdram_cmd_t command,
  input logic                      grant_rand,
  input logic                      grant_bulk
);
  import sdram_cmd_pkg::*;

  int noop_run;        // noop cycles since the last command
  int need_gap;        // gap owed by the last command
  int fail_count = 0;  // failed assertions so far

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      noop_run <= 0;
      need_gap <= 0;
    end
    else if (command != cmd_noop)
    begin
      noop_run <= 0;
      case (command)
        cmd_arsr: need_gap <= T_RFC;
        cmd_actv: need_gap <= T_RCD;
        cmd_prch: need_gap <= T_RP;
        default:  need_gap <= T_RW;
      endcase
    end
    else if (noop_run < 255)
      noop_run <= noop_run + 1;  // saturates
  end

  gap_kept: assert property (@(posedge CLK) disable iff (!RST)
    (command != cmd_noop) |-> (noop_run >= need_gap))
    else
    begin
      fail_count++;
      $error("command issued before the previous gap elapsed");
    end

  grant_single: assert property (@(posedge CLK) disable iff (!RST)
    !(grant_rand && grant_bulk))
    else
    begin
      fail_count++;
      $error("both grants high in one cycle");
    end

  grant_on_access: assert property (@(posedge CLK) disable iff (!RST)
    (grant_rand || grant_bulk) |-> ((command == cmd_read) || (command == cmd_wrte)))
    else
    begin
      fail_count++;
      $error("grant without READ or WRTE");
    end

endmodule

bind sdram_cmd_ctrl sdram_cmd_chk #(
  .T_RFC (T_RFC),
  .T_RCD (T_RCD),
  .T_RP  (T_RP),
  .T_RW  (T_RW)
) sdram_cmd_chk_i (
  .CLK        (CLK),
  .RST        (RST),
  .command    (command),
  .grant_rand (grant_rand),
  .grant_bulk (grant_bulk)
);

// File: logic/sdram_cmd_ctrl.sv
`timescale 1ns/1ps

module sdram_cmd_ctrl #(
  parameter int T_RFC = 13,  // refresh to next command
  parameter int T_RCD = 4,   // activate to access
  parameter int T_RP  = 4,   // precharge period
  parameter int T_RW  = 4    // access to next command
) (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       refresh_strobe,
  input  host_port_pkg::port_req_t   rand_req,
  input  host_port_pkg::port_req_t   bulk_req,
  output sdram_cmd_pkg::sdram_cmd_t  command,
  output sdram_cmd_pkg::dev_addr_t   address,
  output sdram_cmd_pkg::bank_t       bank,
  output logic                       grant_rand,
  output logic                       grant_bulk
);
  import sdram_cmd_pkg::*;

  logic       issue;
  logic       timer_done;
  logic       hit_rand;
  logic       hit_bulk;
  logic       page_open;
  sdram_cmd_t next_cmd;
  page_t      open_page;

  cmd_sequencer cmd_sequencer_i (
    .CLK            (CLK),
    .RST            (RST),
    .rand_req       (rand_req),
    .bulk_req       (bulk_req),
    .refresh_strobe (refresh_strobe),
    .hit_rand       (hit_rand),
    .hit_bulk       (hit_bulk),
    .page_open      (page_open),
    .timer_done     (timer_done),
    .issue          (issue),
    .next_cmd       (next_cmd)
  );

  cmd_timer #(
    .T_RFC (T_RFC),
    .T_RCD (T_RCD),
    .T_RP  (T_RP),
    .T_RW  (T_RW)
  ) cmd_timer_i (
    .CLK        (CLK),
    .RST        (RST),
    .issue      (issue),
    .next_cmd   (next_cmd),
    .timer_done (timer_done)
  );

  page_tracker page_tracker_i (
    .CLK       (CLK),
    .RST       (RST),
    .issue     (issue),
    .next_cmd  (next_cmd),
    .rand_req  (rand_req),
    .bulk_req  (bulk_req),
    .hit_rand  (hit_rand),
    .hit_bulk  (hit_bulk),
    .page_open (page_open),
    .open_page (open_page)
  );

  cmd_output_reg cmd_output_reg_i (
    .CLK        (CLK),
    .RST        (RST),
    .issue      (issue),
    .hit_rand   (hit_rand),
    .hit_bulk   (hit_bulk),
    .next_cmd   (next_cmd),
    .rand_req   (rand_req),
    .bulk_req   (bulk_req),
    .open_page  (open_page),
    .command    (command),
    .address    (address),
    .bank       (bank),
    .grant_rand (grant_rand),
    .grant_bulk (grant_bulk)
  );

endmodule

// File: logic/cmd_output_reg.sv
`timescale 1ns/1ps

module cmd_output_reg (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       issue,
  input  logic                       hit_rand,
  input  logic                       hit_bulk,
  input  sdram_cmd_pkg::sdram_cmd_t  next_cmd,
  input  host_port_pkg::port_req_t   rand_req,
  input  host_port_pkg::port_req_t   bulk_req,
  input  sdram_cmd_pkg::page_t       open_page,
  output sdram_cmd_pkg::sdram_cmd_t  command,
  output sdram_cmd_pkg::dev_addr_t   address,
  output sdram_cmd_pkg::bank_t       bank,
  output logic                       grant_rand,
  output logic                       grant_bulk
);
  import sdram_cmd_pkg::*;
  import host_port_pkg::*;

  port_req_t served;
  row_t      req_row;
  bank_t     req_bank;
  col_t      req_col;
  dev_addr_t fmt_addr;
  bank_t     fmt_bank;
  logic      is_rw;

  assign served   = bulk_req.req ? bulk_req : rand_req;  // bulk first
  assign req_row  = served.addr[HOST_ROW_LSB +: $bits(row_t)];
  assign req_bank = served.addr[HOST_BANK_LSB +: $bits(bank_t)];
  assign req_col  = served.addr[HOST_COL_LSB +: $bits(col_t)];
  assign is_rw    = (next_cmd == cmd_read) || (next_cmd == cmd_wrte);

  always_comb
  begin
    fmt_addr = '0;
    fmt_bank = '0;
    case (next_cmd)
      cmd_actv:
      begin
        fmt_addr = {req_row[11:10], 1'b0, req_row[9:0]};  // a10 kept low
        fmt_bank = req_bank;
      end
      cmd_read,
      cmd_wrte:
      begin
        fmt_addr = {req_col, 1'b0};
        fmt_bank = open_page[$bits(bank_t)-1:0];  // bank of the open row
      end
      cmd_prch: fmt_addr = PRCH_ALL_ADDR;
      default:  fmt_addr = '0;
    endcase
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      command    <= cmd_noop;
      address    <= PRCH_ALL_ADDR;
      bank       <= '0;
      grant_rand <= 1'b0;
      grant_bulk <= 1'b0;
    end
    else
    begin
      command    <= issue ? next_cmd : cmd_noop;
      address    <= issue ? fmt_addr : '0;
      bank       <= issue ? fmt_bank : '0;
      grant_bulk <= issue && is_rw && bulk_req.req && hit_bulk;
      grant_rand <= issue && is_rw && !bulk_req.req && hit_rand;
    end
  end

endmodule

// File: logic/page_tracker.sv
`timescale 1ns/1ps

module page_tracker (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       issue,
  input  sdram_cmd_pkg::sdram_cmd_t  next_cmd,
  input  host_port_pkg::port_req_t   rand_req,
  input  host_port_pkg::port_req_t   bulk_req,
  output logic                       hit_rand,
  output logic                       hit_bulk,
  output logic                       page_open,
  output sdram_cmd_pkg::page_t       open_page
);
  import sdram_cmd_pkg::*;
  import host_port_pkg::*;

  page_t rand_page;
  page_t bulk_page;

  // row and bank fields of each request
  assign rand_page = rand_req.addr[HOST_BANK_LSB +: $bits(page_t)];
  assign bulk_page = bulk_req.addr[HOST_BANK_LSB +: $bits(page_t)];

  always_ff @(posedge CLK)
  begin
    if (!RST)
      page_open <= 1'b0;
    else if (issue)
    begin
      case (next_cmd)
        cmd_actv: page_open <= 1'b1;
        cmd_prch: page_open <= 1'b0;  // precharge closes all banks
        default:  page_open <= page_open;
      endcase
    end
  end

  // bulk port wins when both want the row opened
  always_ff @(posedge CLK)
  begin
    if (issue && (next_cmd == cmd_actv))
      open_page <= bulk_req.req ? bulk_page : rand_page;
  end

  assign hit_rand = rand_req.req && page_open && (rand_page == open_page);
  assign hit_bulk = bulk_req.req && page_open && (bulk_page == open_page);

endmodule

// File: logic/cmd_timer.sv
`timescale 1ns/1ps

module cmd_timer #(
  parameter int T_RFC = 13,
  parameter int T_RCD = 4,
  parameter int T_RP  = 4,
  parameter int T_RW  = 4
) (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       issue,
  input  sdram_cmd_pkg::sdram_cmd_t  next_cmd,
  output logic                       timer_done
);
  import sdram_cmd_pkg::*;

  localparam int MAX_A   = (T_RFC > T_RCD) ? T_RFC : T_RCD;
  localparam int MAX_B   = (T_RP > T_RW) ? T_RP : T_RW;
  localparam int MAX_GAP = (MAX_A > MAX_B) ? MAX_A : MAX_B;
  localparam int CNT_W   = $clog2(MAX_GAP + 2);

  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] gap;

  // gap for the command being issued
  always_comb
  begin
    case (next_cmd)
      cmd_arsr: gap = CNT_W'(T_RFC);
      cmd_actv: gap = CNT_W'(T_RCD);
      cmd_prch: gap = CNT_W'(T_RP);
      cmd_read,
      cmd_wrte: gap = CNT_W'(T_RW);
      default:  gap = '0;
    endcase
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
      count <= '0;
    else if (issue)
      count <= gap;
    else if (count != '0)
      count <= count - 1'b1;  // count down to idle
  end

  assign timer_done = (count == '0);

endmodule

// File: logic/cmd_sequencer.sv
`timescale 1ns/1ps

module cmd_sequencer (
  input  logic                       CLK,
  input  logic                       RST,
  input  host_port_pkg::port_req_t   rand_req,
  input  host_port_pkg::port_req_t   bulk_req,
  input  logic                       refresh_strobe,
  input  logic                       hit_rand,
  input  logic                       hit_bulk,
  input  logic                       page_open,
  input  logic                       timer_done,
  output logic                       issue,
  output sdram_cmd_pkg::sdram_cmd_t  next_cmd
);
  import sdram_cmd_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_issue,
    st_settle
  } seq_state_t;

  seq_state_t state;
  sdram_cmd_t pick_cmd;
  sdram_cmd_t cmd_q;
  logic       refresh_ack;
  logic       refresh_pend;
  logic       work;
  logic       start;

  // command for a port access given its hit state
  function automatic sdram_cmd_t access_cmd(input logic hit, input logic we,
                                            input logic open);
    if (hit)
      return we ? cmd_wrte : cmd_read;
    else if (open)
      return cmd_prch;  // wrong page, close it first
    else
      return cmd_actv;
  endfunction

  assign refresh_pend = refresh_strobe ^ refresh_ack;  // strobe toggles per refresh

  always_comb
  begin
    work     = 1'b1;
    pick_cmd = cmd_noop;
    if (refresh_pend)
      pick_cmd = page_open ? cmd_prch : cmd_arsr;
    else if (bulk_req.req)
      pick_cmd = access_cmd(hit_bulk, bulk_req.we, page_open);
    else if (rand_req.req)
      pick_cmd = access_cmd(hit_rand, rand_req.we, page_open);
    else
      work = 1'b0;
  end

  assign start = (state == st_idle) && timer_done && work;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state       <= st_idle;
      refresh_ack <= 1'b0;
    end
    else
    begin
      case (state)
        st_idle:
          if (start)
            state <= st_issue;
        st_issue:
        begin
          if (cmd_q == cmd_arsr)
            refresh_ack <= refresh_strobe;  // refresh served
          state <= st_settle;
        end
        st_settle:
          state <= st_idle;  // page and timer catch up here
        default:
          state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge CLK)
  begin
    if (start)
      cmd_q <= pick_cmd;
  end

  assign issue    = (state == st_issue);
  assign next_cmd = cmd_q;

endmodule

// File: logic/host_port_pkg.sv
package host_port_pkg;

  // host address layout {row, bank, column}
  typedef logic [25:0] host_addr_t;

  localparam int HOST_COL_LSB  = 0;
  localparam int HOST_BANK_LSB = 12;   // also the low end of the page field
  localparam int HOST_ROW_LSB  = 14;

  // one host port request, held until granted
  typedef struct packed {
    logic       req;
    logic       we;     // 1 for write
    host_addr_t addr;
  } port_req_t;

endpackage

// File: logic/sdram_cmd_pkg.sv
package sdram_cmd_pkg;

  // command pins {ras_n, cas_n, we_n}
  typedef enum logic [2:0] {
    cmd_noop = 3'b111,  // no operation
    cmd_actv = 3'b011,  // row open
    cmd_read = 3'b101,
    cmd_wrte = 3'b100,
    cmd_prch = 3'b010,  // row close
    cmd_arsr = 3'b001   // auto refresh
  } sdram_cmd_t;

  typedef logic [11:0] row_t;
  typedef logic [1:0]  bank_t;
  typedef logic [11:0] col_t;

  // open page is row and bank, row in the upper bits
  typedef logic [13:0] page_t;

  // device address pins
  typedef logic [12:0] dev_addr_t;

  // a10 high selects all banks on precharge
  localparam dev_addr_t PRCH_ALL_ADDR = 13'h0400;

endpackage
